/* hdl/ao_periph_pkg.sv */
// ################################################
// Bus structs, word types, address map and
// register offsets of the always-on peripherals
// ################################################

package ao_periph_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [14:0] fast_intr_t;
  typedef logic [7:0]  gpio_t;

  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    word_t addr;
    word_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } obi_resp_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    logic  error;
    word_t rdata;
  } reg_rsp_t;

  localparam int unsigned NUM_AO_PERIPH = 3;
  localparam int unsigned SOC_CTRL_IDX  = 0;
  localparam int unsigned FAST_INTR_IDX = 1;
  localparam int unsigned GPIO_IDX      = 2;

  // Each slot owns a 4 KiB window above the base
  localparam word_t AO_BASE_ADDR = 32'h2000_0000;

  localparam logic [11:0] EXIT_VALID       = 12'h000;
  localparam logic [11:0] EXIT_VALUE       = 12'h004;
  localparam logic [11:0] BOOT_SELECT      = 12'h008;
  localparam logic [11:0] FINTR_PENDING    = 12'h000;
  localparam logic [11:0] FINTR_ENABLE     = 12'h004;
  localparam logic [11:0] GPIO_OUT         = 12'h000;
  localparam logic [11:0] GPIO_EN          = 12'h004;
  localparam logic [11:0] GPIO_IN          = 12'h008;
  localparam logic [11:0] GPIO_INTR_EN     = 12'h00C;
  localparam logic [11:0] GPIO_INTR_STATUS = 12'h010;

  localparam word_t UNMAPPED_RDATA = 32'hBADC_AB1E;

  // Expands byte strobes into a bit mask
  function automatic word_t strb_mask(strb_t strb);
    word_t mask;
    for (int unsigned b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

endpackage : ao_periph_pkg

/* hdl/ao_peripheral_subsystem.sv */
// ################################################
// Always-on peripheral subsystem top level
// ################################################

module ao_peripheral_subsystem #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ao_periph_pkg::obi_req_t   slave_req_i,
  output ao_periph_pkg::obi_resp_t  slave_resp_o,
  input  logic                      boot_select_i,
  output logic                      exit_valid_o,
  output ao_periph_pkg::word_t      exit_value_o,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output ao_periph_pkg::fast_intr_t fast_intr_o,
  input  ao_periph_pkg::gpio_t      gpio_i,
  output ao_periph_pkg::gpio_t      gpio_o,
  output ao_periph_pkg::gpio_t      gpio_en_o,
  output ao_periph_pkg::gpio_t      intr_gpio_o
);

  ao_periph_pkg::obi_req_t  fifo_req;
  logic                     fifo_gnt;
  logic                     fifo_pop;
  ao_periph_pkg::obi_resp_t bridge_rsp;
  ao_periph_pkg::reg_req_t  periph_req;
  ao_periph_pkg::reg_rsp_t  periph_rsp;

  ao_periph_pkg::reg_req_t [ao_periph_pkg::NUM_AO_PERIPH-1:0] slot_req;
  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::NUM_AO_PERIPH-1:0] slot_rsp;

  obi_req_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) obi_req_fifo_i (
    .clk_i,
    .rst_n_i,
    .req_i(slave_req_i),
    .gnt_o(fifo_gnt),
    .req_o(fifo_req),
    .pop_i(fifo_pop)
  );

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_n_i,
    .req_i    (fifo_req),
    .pop_o    (fifo_pop),
    .rsp_o    (bridge_rsp),
    .reg_req_o(periph_req),
    .reg_rsp_i(periph_rsp)
  );

  // Grant comes from the buffer, data from the bridge
  assign slave_resp_o = '{gnt: fifo_gnt, rvalid: bridge_rsp.rvalid, rdata: bridge_rsp.rdata};

  reg_decode_demux reg_decode_demux_i (
    .reg_req_i   (periph_req),
    .reg_rsp_o   (periph_rsp),
    .periph_req_o(slot_req),
    .periph_rsp_i(slot_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slot_req[ao_periph_pkg::SOC_CTRL_IDX]),
    .reg_rsp_o(slot_rsp[ao_periph_pkg::SOC_CTRL_IDX]),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slot_req[ao_periph_pkg::FAST_INTR_IDX]),
    .reg_rsp_o(slot_rsp[ao_periph_pkg::FAST_INTR_IDX]),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio_ao gpio_ao_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slot_req[ao_periph_pkg::GPIO_IDX]),
    .reg_rsp_o(slot_rsp[ao_periph_pkg::GPIO_IDX]),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_gpio_o
  );

endmodule : ao_peripheral_subsystem

/* hdl/fast_intr_ctrl.sv */
// ################################################
// Fast interrupt pending and enable registers
// ################################################

module fast_intr_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ao_periph_pkg::reg_req_t   reg_req_i,
  output ao_periph_pkg::reg_rsp_t   reg_rsp_o,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output ao_periph_pkg::fast_intr_t fast_intr_o
);

  ao_periph_pkg::fast_intr_t pending_q;
  ao_periph_pkg::fast_intr_t enable_q;
  ao_periph_pkg::fast_intr_t clr;
  ao_periph_pkg::word_t      wmask;
  logic [11:0]               offset;
  logic                      wr_en;

  assign offset = reg_req_i.addr[11:0];
  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign wmask  = ao_periph_pkg::strb_mask(reg_req_i.wstrb);

  // Write one to clear
  assign clr = (wr_en && offset == ao_periph_pkg::FINTR_PENDING) ?
               reg_req_i.wdata[14:0] & wmask[14:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A line held high keeps its bit set
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (wr_en && offset == ao_periph_pkg::FINTR_ENABLE) begin
        enable_q <= (enable_q & ~wmask[14:0]) | (reg_req_i.wdata[14:0] & wmask[14:0]);
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    unique case (offset)
      ao_periph_pkg::FINTR_PENDING: reg_rsp_o.rdata = {17'b0, pending_q};
      ao_periph_pkg::FINTR_ENABLE:  reg_rsp_o.rdata = {17'b0, enable_q};
      default:                      reg_rsp_o.rdata = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule : fast_intr_ctrl

/* hdl/gpio_ao.sv */
// ################################################
// Always-on GPIO with input sync and edge IRQs
// ################################################

module gpio_ao (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  ao_periph_pkg::gpio_t    gpio_i,
  output ao_periph_pkg::gpio_t    gpio_o,
  output ao_periph_pkg::gpio_t    gpio_en_o,
  output ao_periph_pkg::gpio_t    intr_gpio_o
);

  ao_periph_pkg::gpio_t sync1_q;
  ao_periph_pkg::gpio_t sync2_q;
  ao_periph_pkg::gpio_t prev_q;
  ao_periph_pkg::gpio_t out_q;
  ao_periph_pkg::gpio_t en_q;
  ao_periph_pkg::gpio_t intr_en_q;
  ao_periph_pkg::gpio_t status_q;
  ao_periph_pkg::gpio_t rise;
  ao_periph_pkg::gpio_t wdata;
  ao_periph_pkg::gpio_t clr;
  ao_periph_pkg::word_t wmask;
  logic [11:0]          offset;
  logic                 wr_en;

  assign offset = reg_req_i.addr[11:0];
  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign wmask  = ao_periph_pkg::strb_mask(reg_req_i.wstrb);
  assign wdata  = reg_req_i.wdata[7:0] & wmask[7:0];
  assign rise   = sync2_q & ~prev_q;
  assign clr    = (wr_en && offset == ao_periph_pkg::GPIO_INTR_STATUS) ? wdata : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      status_q <= (status_q & ~clr) | rise;
      if (wr_en) begin
        unique case (offset)
          ao_periph_pkg::GPIO_OUT:     out_q     <= (out_q & ~wmask[7:0]) | wdata;
          ao_periph_pkg::GPIO_EN:      en_q      <= (en_q & ~wmask[7:0]) | wdata;
          ao_periph_pkg::GPIO_INTR_EN: intr_en_q <= (intr_en_q & ~wmask[7:0]) | wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    unique case (offset)
      ao_periph_pkg::GPIO_OUT:         reg_rsp_o.rdata = {24'b0, out_q};
      ao_periph_pkg::GPIO_EN:          reg_rsp_o.rdata = {24'b0, en_q};
      ao_periph_pkg::GPIO_IN:          reg_rsp_o.rdata = {24'b0, sync2_q};
      ao_periph_pkg::GPIO_INTR_EN:     reg_rsp_o.rdata = {24'b0, intr_en_q};
      ao_periph_pkg::GPIO_INTR_STATUS: reg_rsp_o.rdata = {24'b0, status_q};
      default:                         reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_en_o   = en_q;
  assign intr_gpio_o = status_q & intr_en_q;

endmodule : gpio_ao

/* hdl/obi_req_fifo.sv */
// ################################################
// OBI request buffer, circular with count
// ################################################

module obi_req_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::obi_req_t req_i,
  output logic                    gnt_o,
  output ao_periph_pkg::obi_req_t req_o,
  input  logic                    pop_i
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

  ao_periph_pkg::obi_req_t mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             not_empty;
  logic             push;
  logic             pop;

  assign not_empty = (count_q != '0);
  // Grant depends on fill level only
  assign gnt_o     = (count_q != FULL_COUNT);
  assign push      = req_i.req & gnt_o;
  assign pop       = pop_i & not_empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_comb begin
    req_o     = mem_q[rd_ptr_q];
    req_o.req = not_empty;
  end

endmodule : obi_req_fifo

/* hdl/obi_to_reg.sv */
// ################################################
// Bridge from buffered OBI requests to the
// register bus, with registered read response
// ################################################

module obi_to_reg (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ao_periph_pkg::obi_req_t  req_i,
  output logic                     pop_o,
  output ao_periph_pkg::obi_resp_t rsp_o,
  output ao_periph_pkg::reg_req_t  reg_req_o,
  input  ao_periph_pkg::reg_rsp_t  reg_rsp_i
);

  logic                 rvalid_q;
  ao_periph_pkg::word_t rdata_q;
  logic                 handshake;

  // Hold off while a response leaves this cycle
  always_comb begin
    reg_req_o.valid = req_i.req & ~rvalid_q;
    reg_req_o.write = req_i.we;
    reg_req_o.addr  = req_i.addr;
    reg_req_o.wdata = req_i.wdata;
    reg_req_o.wstrb = req_i.be;
  end

  assign handshake = reg_req_o.valid & reg_rsp_i.ready;
  assign pop_o     = handshake;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= handshake;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (handshake) begin
      rdata_q <= req_i.we ? '0 : reg_rsp_i.rdata;
    end
  end

  always_comb begin
    rsp_o.gnt    = 1'b0;
    rsp_o.rvalid = rvalid_q;
    rsp_o.rdata  = rdata_q;
  end

endmodule : obi_to_reg

/* hdl/reg_decode_demux.sv */
// ################################################
// Address decoder and register-bus demux
// ################################################

module reg_decode_demux (
  input  ao_periph_pkg::reg_req_t                              reg_req_i,
  output ao_periph_pkg::reg_rsp_t                              reg_rsp_o,
  output ao_periph_pkg::reg_req_t [ao_periph_pkg::NUM_AO_PERIPH-1:0] periph_req_o,
  input  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::NUM_AO_PERIPH-1:0] periph_rsp_i
);

  localparam int unsigned SEL_W = $clog2(ao_periph_pkg::NUM_AO_PERIPH);
  localparam logic [19:0] BASE_PAGE = ao_periph_pkg::AO_BASE_ADDR[31:12];

  logic [SEL_W-1:0] sel;
  logic             hit;

  // Match the 4 KiB page against each slot
  always_comb begin
    hit = 1'b0;
    sel = '0;
    for (int unsigned i = 0; i < ao_periph_pkg::NUM_AO_PERIPH; i++) begin
      if (reg_req_i.addr[31:12] == BASE_PAGE + 20'(i)) begin
        hit = 1'b1;
        sel = SEL_W'(i);
      end
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < ao_periph_pkg::NUM_AO_PERIPH; i++) begin
      periph_req_o[i]       = reg_req_i;
      periph_req_o[i].addr  = {20'b0, reg_req_i.addr[11:0]};
      periph_req_o[i].valid = reg_req_i.valid & hit & (sel == SEL_W'(i));
    end
  end

  // Unmapped accesses are answered here
  always_comb begin
    if (hit) begin
      reg_rsp_o = periph_rsp_i[sel];
    end else begin
      reg_rsp_o.ready = 1'b1;
      reg_rsp_o.error = 1'b1;
      reg_rsp_o.rdata = ao_periph_pkg::UNMAPPED_RDATA;
    end
  end

endmodule : reg_decode_demux

/* hdl/soc_ctrl.sv */
// ################################################
// SoC control: exit flag, exit value, boot select
// ################################################

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output ao_periph_pkg::word_t    exit_value_o
);

  logic                 exit_valid_q;
  ao_periph_pkg::word_t exit_value_q;
  ao_periph_pkg::word_t wmask;
  logic [11:0]          offset;
  logic                 wr_en;

  assign offset = reg_req_i.addr[11:0];
  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  assign wmask  = ao_periph_pkg::strb_mask(reg_req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      if (offset == ao_periph_pkg::EXIT_VALID && wmask[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (offset == ao_periph_pkg::EXIT_VALUE) begin
        exit_value_q <= (exit_value_q & ~wmask) | (reg_req_i.wdata & wmask);
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = 1'b0;
    unique case (offset)
      ao_periph_pkg::EXIT_VALID:  reg_rsp_o.rdata = {31'b0, exit_valid_q};
      ao_periph_pkg::EXIT_VALUE:  reg_rsp_o.rdata = exit_value_q;
      ao_periph_pkg::BOOT_SELECT: reg_rsp_o.rdata = {31'b0, boot_select_i};
      default:                    reg_rsp_o.rdata = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

/* list.f */
hdl/ao_periph_pkg.sv
hdl/obi_req_fifo.sv
hdl/obi_to_reg.sv
hdl/reg_decode_demux.sv
hdl/soc_ctrl.sv
hdl/fast_intr_ctrl.sv
hdl/gpio_ao.sv
hdl/ao_peripheral_subsystem.sv
verification/tb_ao_peripheral_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the subsystem testbench
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_ao_peripheral_subsystem -f list.f \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_ao_peripheral_subsystem > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"

/* verification/ao_periph_stimulus.txt */
# op addr data strb name, hex fields; RD compares read data with data, PB/PF/PG set pins to data
# CHK output selector in addr: 0 exit_valid 1 exit_value 2 fast_intr 3 gpio 4 gpio_en 5 intr_gpio
PB  00000000 00000001 0 boot_pin_high
CHK 00000000 00000000 0 rst_exit_valid
CHK 00000002 00000000 0 rst_fast_intr
CHK 00000003 00000000 0 rst_gpio_out
CHK 00000004 00000000 0 rst_gpio_en
CHK 00000005 00000000 0 rst_intr_gpio
B2B 00000000 00000001 0 burst_on
RD  20000000 00000000 0 rst_exit_flag
RD  20000004 00000000 0 rst_exit_value
RD  20000008 00000001 0 rst_boot_select
RD  20001000 00000000 0 rst_fintr_pending
RD  20001004 00000000 0 rst_fintr_enable
RD  20002000 00000000 0 rst_gpio_out_reg
RD  20002004 00000000 0 rst_gpio_en_reg
RD  20002008 00000000 0 rst_gpio_in
RD  2000200C 00000000 0 rst_gpio_intr_en
RD  20002010 00000000 0 rst_gpio_status
B2B 00000000 00000000 0 burst_off
WR  20000004 12345678 3 exit_value_low
WR  20000004 AABBCCDD C exit_value_high
RD  20000004 AABB5678 0 exit_value_merged
WR  20000000 00000001 1 exit_flag_set
CHK 00000000 00000001 0 exit_valid_high
CHK 00000001 AABB5678 0 exit_value_pins
B2B 00000000 00000001 0 burst_on
WR  20002000 0000005A F gpio_out_wr
WR  20002004 000000F0 F gpio_en_wr
RD  20002000 0000005A 0 gpio_out_rd
RD  20002004 000000F0 0 gpio_en_rd
RD  20000004 AABB5678 0 burst_exit_value
B2B 00000000 00000000 0 burst_off
CHK 00000003 0000005A 0 gpio_out_pins
CHK 00000004 000000F0 0 gpio_en_pins
WR  20001004 00000005 F fintr_enable_wr
PF  00000000 00000007 0 fintr_lines_high
RD  20001000 00000007 0 fintr_pending_set
CHK 00000002 00000005 0 fintr_out_masked
PF  00000000 00000000 0 fintr_lines_low
WR  20001000 00000003 F fintr_clear_low
RD  20001000 00000004 0 fintr_pending_left
CHK 00000002 00000004 0 fintr_out_left
WR  2000200C 00000001 F gpio_intr_en_wr
PG  00000000 00000003 0 gpio_in_rise
RD  20002008 00000003 0 gpio_in_sync
RD  20002010 00000003 0 gpio_status_set
CHK 00000005 00000001 0 gpio_intr_masked
WR  20002010 00000001 F gpio_status_clear
RD  20002010 00000002 0 gpio_status_left
CHK 00000005 00000000 0 gpio_intr_cleared
RD  20003000 BADCAB1E 0 unmapped_page
RD  10000000 BADCAB1E 0 unmapped_low
WR  20003000 FFFFFFFF F unmapped_write
RD  20000004 AABB5678 0 keep_exit_value
RD  20001000 00000004 0 keep_fintr_pending
RD  20002000 0000005A 0 keep_gpio_out
CHK 00000000 00000001 0 keep_exit_valid

/* verification/tb_ao_peripheral_subsystem.sv */
// ################################################
// Testbench for the always-on peripheral subsystem
// File-driven OBI driver, pin driver, compare tasks
// ################################################

module tb_ao_peripheral_subsystem;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned FIFO_DEPTH    = 2;
  localparam int unsigned TIMEOUT       = 100;
  localparam int unsigned SETTLE_CYCLES = 4;

  logic                      clk_i = 1'b0;
  logic                      rst_n_i;
  ao_periph_pkg::obi_req_t   slave_req;
  ao_periph_pkg::obi_resp_t  slave_resp;
  logic                      boot_select_i;
  logic                      exit_valid_o;
  ao_periph_pkg::word_t      exit_value_o;
  ao_periph_pkg::fast_intr_t fast_intr_i;
  ao_periph_pkg::fast_intr_t fast_intr_o;
  ao_periph_pkg::gpio_t      gpio_i;
  ao_periph_pkg::gpio_t      gpio_o;
  ao_periph_pkg::gpio_t      gpio_en_o;
  ao_periph_pkg::gpio_t      intr_gpio_o;

  logic [31:0]          rng_state = 32'h989181e5;
  logic                 back_to_back;
  ao_periph_pkg::word_t exp_data_q[$];
  string                exp_name_q[$];

  ao_peripheral_subsystem #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) UUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .slave_req_i  (slave_req),
    .slave_resp_o (slave_resp),
    .boot_select_i(boot_select_i),
    .exit_valid_o (exit_valid_o),
    .exit_value_o (exit_value_o),
    .fast_intr_i  (fast_intr_i),
    .fast_intr_o  (fast_intr_o),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_en_o    (gpio_en_o),
    .intr_gpio_o  (intr_gpio_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic end_with_failure();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("ERROR: %s", what);
    end_with_failure();
  endtask

  task automatic check_word(input string name, input ao_periph_pkg::word_t exp,
                            input ao_periph_pkg::word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_fast_intr(input string name, input ao_periph_pkg::fast_intr_t exp,
                                 input ao_periph_pkg::fast_intr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_gpio(input string name, input ao_periph_pkg::gpio_t exp,
                            input ao_periph_pkg::gpio_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end_with_failure();
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic issue_request(input logic we, input ao_periph_pkg::word_t addr,
                               input ao_periph_pkg::word_t wdata,
                               input ao_periph_pkg::strb_t be,
                               input ao_periph_pkg::word_t exp, input string name);
    int unsigned gap;
    int unsigned waited;
    rng_state = xorshift32(rng_state);
    gap = back_to_back ? 0 : rng_state % 4;
    repeat (gap) next_cycle();
    slave_req.req   = 1'b1;
    slave_req.we    = we;
    slave_req.be    = be;
    slave_req.addr  = addr;
    slave_req.wdata = wdata;
    // Grant only moves on the rising edge
    waited = 0;
    @(negedge clk_i);
    while (slave_resp.gnt !== 1'b1) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_problem({"timeout waiting for grant in ", name});
      end
      @(negedge clk_i);
    end
    exp_data_q.push_back(exp);
    exp_name_q.push_back(name);
    next_cycle();
    slave_req = '0;
  endtask

  task automatic drain_responses();
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    #1;
    while (exp_data_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_problem("timeout waiting for read valid");
      end
      @(negedge clk_i);
      #1;
    end
  endtask

  // Synchronizer and edge detect need three edges
  task automatic settle_pins();
    int unsigned cycles;
    cycles = 0;
    while (cycles < SETTLE_CYCLES) begin
      next_cycle();
      cycles++;
    end
  endtask

  task automatic drive_pin(input string op, input ao_periph_pkg::word_t value);
    drain_responses();
    next_cycle();
    case (op)
      "PB":    boot_select_i = value[0];
      "PF":    fast_intr_i = value[14:0];
      default: gpio_i = value[7:0];
    endcase
    settle_pins();
  endtask

  task automatic check_output(input ao_periph_pkg::word_t sel, input ao_periph_pkg::word_t exp,
                              input string name);
    drain_responses();
    case (sel)
      32'd0:   check_word(name, exp, {31'b0, exit_valid_o});
      32'd1:   check_word(name, exp, exit_value_o);
      32'd2:   check_fast_intr(name, exp[14:0], fast_intr_o);
      32'd3:   check_gpio(name, exp[7:0], gpio_o);
      32'd4:   check_gpio(name, exp[7:0], gpio_en_o);
      32'd5:   check_gpio(name, exp[7:0], intr_gpio_o);
      default: report_problem({"unknown output selector in ", name});
    endcase
    next_cycle();
  endtask

  // Response monitor, one expected entry per read valid
  always @(negedge clk_i) begin
    if (rst_n_i && slave_resp.rvalid === 1'b1) begin
      if (exp_data_q.size() == 0) begin
        report_problem("read valid without an outstanding request");
      end else begin
        check_word(exp_name_q.pop_front(), exp_data_q.pop_front(), slave_resp.rdata);
      end
    end
  end

  initial begin
    int                   fd;
    int                   fields;
    string                line;
    string                op;
    string                name;
    ao_periph_pkg::word_t a;
    ao_periph_pkg::word_t b;
    ao_periph_pkg::word_t c;

    rst_n_i       = 1'b0;
    slave_req     = '0;
    boot_select_i = 1'b0;
    fast_intr_i   = '0;
    gpio_i        = '0;
    back_to_back  = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    fd = $fopen("verification/ao_periph_stimulus.txt", "r");
    if (fd == 0) begin
      report_problem("cannot open the stimulus file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%s %h %h %h %s", op, a, b, c, name);
      if (fields != 5) begin
        report_problem({"malformed stimulus line ", line});
      end
      case (op)
        "RD":             issue_request(1'b0, a, '0, 4'hF, b, name);
        "WR":             issue_request(1'b1, a, b, c[3:0], '0, name);
        "B2B":            back_to_back = b[0];
        "PB", "PF", "PG": drive_pin(op, b);
        "CHK":            check_output(a, b, name);
        default:          report_problem({"unknown stimulus operation ", op});
      endcase
    end
    $fclose(fd);

    // Quiet cycles catch a stray read valid
    drain_responses();
    repeat (3) next_cycle();
    $display("All tests passed!");
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem
